/* source/dpc_pkg.sv */
// ====================
// dpc shared definitions
// widths, table size, bus address map and stream types
// ====================

package dpc_pkg;

  localparam int PIXEL_WIDTH     = 14;
  localparam int COORD_WIDTH     = 10;
  localparam int BP_TABLE_DEPTH  = 16;
  localparam int BP_INDEX_WIDTH  = 4;
  localparam int BP_COUNT_WIDTH  = 5;
  localparam int WB_ADDR_WIDTH   = 5;
  localparam int WB_DATA_WIDTH   = 32;

  // address map
  localparam logic [WB_ADDR_WIDTH-1:0] ADDR_CTRL = '0;
  localparam int ADDR_TABLE_FLAG = 4;

  typedef logic [PIXEL_WIDTH-1:0] pixel_t;
  typedef logic [COORD_WIDTH-1:0] coord_t;

  // one stream word, 16 bits
  typedef struct packed {
    pixel_t data;
    logic   sof;
    logic   eol;
  } video_beat_t;

  typedef struct packed {
    coord_t x;
    coord_t y;
  } bp_entry_t;

  // enable at bit 8, count in the low bits
  typedef struct packed {
    logic [22:0]               pad_hi;
    logic                      enable;
    logic [2:0]                pad_lo;
    logic [BP_COUNT_WIDTH-1:0] count;
  } ctrl_word_t;

  // table entry as seen on the bus, y at 25:16, x at 9:0
  typedef struct packed {
    logic [5:0] pad_hi;
    coord_t     y;
    logic [5:0] pad_lo;
    coord_t     x;
  } bp_word_t;

  typedef union packed {
    ctrl_word_t ctrl;
    bp_word_t   entry;
  } cfg_word_u;

  typedef bp_entry_t [BP_TABLE_DEPTH-1:0] bp_table_t;

endpackage

/* source/dpc_cfg_wb.sv */
// ====================
// dpc configuration slave
// wishbone classic port holding the control word and bad-pixel table
// ====================

module dpc_cfg_wb
  import dpc_pkg::*;
(
  input  logic                      axis_aclk,
  input  logic                      axis_aresetn,
  input  logic                      wb_cyc,
  input  logic                      wb_stb,
  input  logic                      wb_we,
  input  logic [WB_ADDR_WIDTH-1:0]  wb_adr,
  input  cfg_word_u                 wb_dat_w,
  output logic [WB_DATA_WIDTH-1:0]  wb_dat_r,
  output logic                      wb_ack,
  output bp_table_t                 bp_table,
  output logic                      correct_enable,
  output logic [BP_COUNT_WIDTH-1:0] bp_count
);

  logic                      req;
  logic                      table_sel;
  logic                      ctrl_sel;
  logic [BP_INDEX_WIDTH-1:0] index;
  cfg_word_u                 rd_word;

  // new request only, so ack never lasts two cycles
  assign req       = wb_cyc & wb_stb & ~wb_ack;
  assign table_sel = wb_adr[ADDR_TABLE_FLAG];
  assign ctrl_sel  = (wb_adr == ADDR_CTRL);
  assign index     = wb_adr[BP_INDEX_WIDTH-1:0];

  // readback word, padding zero
  always_comb
  begin
    rd_word = '0;
    if (table_sel)
    begin
      rd_word.entry.x = bp_table[index].x;
      rd_word.entry.y = bp_table[index].y;
    end
    else if (ctrl_sel)
    begin
      rd_word.ctrl.enable = correct_enable;
      rd_word.ctrl.count  = bp_count;
    end
  end

  always_ff @(posedge axis_aclk or negedge axis_aresetn)
  begin
    if (!axis_aresetn)
    begin
      wb_ack         <= 1'b0;
      correct_enable <= 1'b0;
      bp_count       <= '0;
      bp_table       <= '0;
    end
    else
    begin
      wb_ack <= req;
      if (req && wb_we)
      begin
        if (table_sel)
        begin
          bp_table[index].x <= wb_dat_w.entry.x;
          bp_table[index].y <= wb_dat_w.entry.y;
        end
        else if (ctrl_sel)
        begin
          correct_enable <= wb_dat_w.ctrl.enable;
          bp_count       <= wb_dat_w.ctrl.count;
        end
      end
    end
  end

  // read data rides with ack
  always_ff @(posedge axis_aclk)
  begin
    if (req)
      wb_dat_r <= rd_word;
  end

endmodule

/* source/dpc_pixel_locator.sv */
// ====================
// pixel locator
// tracks column and row, flags pixels listed in the table
// ====================

module dpc_pixel_locator
  import dpc_pkg::*;
(
  input  logic                      axis_aclk,
  input  logic                      axis_aresetn,
  input  logic                      s_axis_tvalid,
  output logic                      s_axis_tready,
  input  pixel_t                    s_axis_tdata,
  input  logic                      s_axis_tuser,
  input  logic                      s_axis_tlast,
  input  bp_table_t                 bp_table,
  input  logic                      correct_enable,
  input  logic [BP_COUNT_WIDTH-1:0] bp_count,
  output logic                      loc_valid,
  input  logic                      loc_ready,
  output video_beat_t               loc_beat,
  output logic                      loc_bad
);

  coord_t    col;
  coord_t    row;
  bp_entry_t cur_pos;
  logic      hit;
  logic      accept;

  assign s_axis_tready = ~loc_valid | loc_ready;
  assign accept        = s_axis_tvalid & s_axis_tready;

  // sof forces position 0,0
  assign cur_pos.x = s_axis_tuser ? '0 : col;
  assign cur_pos.y = s_axis_tuser ? '0 : row;

  // only entries below the loaded count take part
  always_comb
  begin
    hit = 1'b0;
    for (int i = 0; i < BP_TABLE_DEPTH; i++)
    begin
      if ((BP_COUNT_WIDTH'(i) < bp_count) && (bp_table[i] == cur_pos))
        hit = 1'b1;
    end
  end

  always_ff @(posedge axis_aclk or negedge axis_aresetn)
  begin
    if (!axis_aresetn)
    begin
      loc_valid <= 1'b0;
      col       <= '0;
      row       <= '0;
    end
    else
    begin
      if (s_axis_tready)
        loc_valid <= s_axis_tvalid;
      if (accept)
      begin
        col <= s_axis_tlast ? '0 : cur_pos.x + 1'b1;
        row <= s_axis_tlast ? cur_pos.y + 1'b1 : cur_pos.y;
      end
    end
  end

  always_ff @(posedge axis_aclk)
  begin
    if (accept)
    begin
      loc_beat <= '{data: s_axis_tdata, sof: s_axis_tuser, eol: s_axis_tlast};
      loc_bad  <= correct_enable & hit;
    end
  end

endmodule

/* source/dpc_pixel_replacer.sv */
// ====================
// pixel replacer
// flagged pixels take the corrected left neighbor
// ====================

module dpc_pixel_replacer
  import dpc_pkg::*;
(
  input  logic        axis_aclk,
  input  logic        axis_aresetn,
  input  logic        loc_valid,
  output logic        loc_ready,
  input  video_beat_t loc_beat,
  input  logic        loc_bad,
  output logic        rep_valid,
  input  logic        rep_ready,
  output video_beat_t rep_beat
);

  pixel_t last_pix;
  logic   has_left;
  logic   accept;
  logic   use_left;
  pixel_t out_pix;

  assign loc_ready = ~rep_valid | rep_ready;
  assign accept    = loc_valid & loc_ready;

  // a sof pixel is column 0 and never has a neighbor
  assign use_left = loc_bad & has_left & ~loc_beat.sof;
  assign out_pix  = use_left ? last_pix : loc_beat.data;

  always_ff @(posedge axis_aclk or negedge axis_aresetn)
  begin
    if (!axis_aresetn)
    begin
      rep_valid <= 1'b0;
      has_left  <= 1'b0;
    end
    else
    begin
      if (loc_ready)
        rep_valid <= loc_valid;
      if (accept)
        has_left <= ~loc_beat.eol;
    end
  end

  always_ff @(posedge axis_aclk)
  begin
    if (accept)
    begin
      last_pix <= out_pix;
      rep_beat <= '{data: out_pix, sof: loc_beat.sof, eol: loc_beat.eol};
    end
  end

endmodule

/* source/dpc_output_skid.sv */
// ====================
// output skid buffer
// output register plus a spare entry, registered upstream ready
// ====================

module dpc_output_skid
  import dpc_pkg::*;
(
  input  logic        axis_aclk,
  input  logic        axis_aresetn,
  input  logic        rep_valid,
  output logic        rep_ready,
  input  video_beat_t rep_beat,
  output logic        m_axis_tvalid,
  input  logic        m_axis_tready,
  output pixel_t      m_axis_tdata,
  output logic        m_axis_tuser,
  output logic        m_axis_tlast
);

  video_beat_t out_beat;
  video_beat_t spare_beat;
  logic        spare_valid;
  logic        accept;
  logic        out_free;

  assign rep_ready = ~spare_valid;
  assign accept    = rep_valid & rep_ready;
  assign out_free  = ~m_axis_tvalid | m_axis_tready;

  always_ff @(posedge axis_aclk or negedge axis_aresetn)
  begin
    if (!axis_aresetn)
    begin
      m_axis_tvalid <= 1'b0;
      spare_valid   <= 1'b0;
    end
    else if (out_free)
    begin
      // spare drains first to keep order
      m_axis_tvalid <= spare_valid | accept;
      spare_valid   <= 1'b0;
    end
    else if (accept)
      spare_valid <= 1'b1;
  end

  always_ff @(posedge axis_aclk)
  begin
    if (out_free)
      out_beat <= spare_valid ? spare_beat : rep_beat;
    else if (accept)
      spare_beat <= rep_beat;
  end

  assign m_axis_tdata = out_beat.data;
  assign m_axis_tuser = out_beat.sof;
  assign m_axis_tlast = out_beat.eol;

endmodule

/* source/dpc_top.sv */
// ====================
// defective pixel corrector top
// config slave, locator, replacer and output buffer
// ====================

module dpc_top
  import dpc_pkg::*;
(
  input  logic                     axis_aclk,
  input  logic                     axis_aresetn,
  // pixel input
  input  logic                     s_axis_tvalid,
  output logic                     s_axis_tready,
  input  pixel_t                   s_axis_tdata,
  input  logic                     s_axis_tuser,
  input  logic                     s_axis_tlast,
  // pixel output
  output logic                     m_axis_tvalid,
  input  logic                     m_axis_tready,
  output pixel_t                   m_axis_tdata,
  output logic                     m_axis_tuser,
  output logic                     m_axis_tlast,
  // configuration bus
  input  logic                     wb_cyc,
  input  logic                     wb_stb,
  input  logic                     wb_we,
  input  logic [WB_ADDR_WIDTH-1:0] wb_adr,
  input  cfg_word_u                wb_dat_w,
  output logic [WB_DATA_WIDTH-1:0] wb_dat_r,
  output logic                     wb_ack
);

  bp_table_t                 bp_table;
  logic                      correct_enable;
  logic [BP_COUNT_WIDTH-1:0] bp_count;
  logic                      loc_valid;
  logic                      loc_ready;
  video_beat_t               loc_beat;
  logic                      loc_bad;
  logic                      rep_valid;
  logic                      rep_ready;
  video_beat_t               rep_beat;

  dpc_cfg_wb u_cfg_wb (
    .axis_aclk      (axis_aclk),
    .axis_aresetn   (axis_aresetn),
    .wb_cyc         (wb_cyc),
    .wb_stb         (wb_stb),
    .wb_we          (wb_we),
    .wb_adr         (wb_adr),
    .wb_dat_w       (wb_dat_w),
    .wb_dat_r       (wb_dat_r),
    .wb_ack         (wb_ack),
    .bp_table       (bp_table),
    .correct_enable (correct_enable),
    .bp_count       (bp_count)
  );

  dpc_pixel_locator u_pixel_locator (
    .axis_aclk      (axis_aclk),
    .axis_aresetn   (axis_aresetn),
    .s_axis_tvalid  (s_axis_tvalid),
    .s_axis_tready  (s_axis_tready),
    .s_axis_tdata   (s_axis_tdata),
    .s_axis_tuser   (s_axis_tuser),
    .s_axis_tlast   (s_axis_tlast),
    .bp_table       (bp_table),
    .correct_enable (correct_enable),
    .bp_count       (bp_count),
    .loc_valid      (loc_valid),
    .loc_ready      (loc_ready),
    .loc_beat       (loc_beat),
    .loc_bad        (loc_bad)
  );

  dpc_pixel_replacer u_pixel_replacer (
    .axis_aclk    (axis_aclk),
    .axis_aresetn (axis_aresetn),
    .loc_valid    (loc_valid),
    .loc_ready    (loc_ready),
    .loc_beat     (loc_beat),
    .loc_bad      (loc_bad),
    .rep_valid    (rep_valid),
    .rep_ready    (rep_ready),
    .rep_beat     (rep_beat)
  );

  dpc_output_skid u_output_skid (
    .axis_aclk     (axis_aclk),
    .axis_aresetn  (axis_aresetn),
    .rep_valid     (rep_valid),
    .rep_ready     (rep_ready),
    .rep_beat      (rep_beat),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tuser  (m_axis_tuser),
    .m_axis_tlast  (m_axis_tlast)
  );

endmodule

/* tests/tb_clock_gen.sv */
// ====================
// testbench clock and reset
// 100 ns clock, reset low for 5 cycles
// ====================

module tb_clock_gen
(
  output logic axis_aclk,
  output logic axis_aresetn
);

  timeunit 1ns;
  timeprecision 1ps;

  initial
  begin
    axis_aclk = 1'b0;
    forever #50 axis_aclk = ~axis_aclk;
  end

  // release on a falling edge
  initial
  begin
    axis_aresetn = 1'b0;
    repeat (5) @(negedge axis_aclk);
    axis_aresetn = 1'b1;
  end

endmodule

/* tests/dpc_top_props.sv */
// ====================
// dpc_top stream and bus assertions
// ====================

module dpc_top_props
  import dpc_pkg::*;
(
  input logic   axis_aclk,
  input logic   axis_aresetn,
  input logic   m_axis_tvalid,
  input logic   m_axis_tready,
  input pixel_t m_axis_tdata,
  input logic   m_axis_tuser,
  input logic   m_axis_tlast,
  input logic   wb_cyc,
  input logic   wb_stb,
  input logic   wb_ack
);

  timeunit 1ns;
  timeprecision 1ps;

  // stalled output beat holds until taken
  out_hold: assert property (@(posedge axis_aclk) disable iff (!axis_aresetn)
    m_axis_tvalid && !m_axis_tready |=>
      m_axis_tvalid && $stable({m_axis_tdata, m_axis_tuser, m_axis_tlast}))
    else $error("output beat dropped or changed while stalled");

  // ack rises on the edge after a request was seen
  ack_req: assert property (@(posedge axis_aclk) disable iff (!axis_aresetn)
    $rose(wb_ack) |-> $past(wb_cyc && wb_stb))
    else $error("wishbone ack without cyc and stb");

  ack_single: assert property (@(posedge axis_aclk) disable iff (!axis_aresetn)
    wb_ack |=> !wb_ack)
    else $error("wishbone ack held for two cycles");

  reset_quiet: assert property (@(posedge axis_aclk) !axis_aresetn |-> !m_axis_tvalid)
    else $error("output valid during reset");

endmodule

bind dpc_top dpc_top_props u_dpc_top_props (.*);

/* tests/dpc_top_tb.sv */
// ====================
// dpc_top testbench
// file driven bus access, fixed frames and a random frame
// ====================

module dpc_top_tb
  import dpc_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  typedef struct packed {
    logic [7:0]  kind;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
  } stim_rec_t;

  logic                     axis_aclk;
  logic                     axis_aresetn;
  logic                     s_axis_tvalid;
  logic                     s_axis_tready;
  pixel_t                   s_axis_tdata;
  logic                     s_axis_tuser;
  logic                     s_axis_tlast;
  logic                     m_axis_tvalid;
  logic                     m_axis_tready;
  pixel_t                   m_axis_tdata;
  logic                     m_axis_tuser;
  logic                     m_axis_tlast;
  logic                     wb_cyc;
  logic                     wb_stb;
  logic                     wb_we;
  logic [WB_ADDR_WIDTH-1:0] wb_adr;
  cfg_word_u                wb_dat_w;
  logic [WB_DATA_WIDTH-1:0] wb_dat_r;
  logic                     wb_ack;

  stim_rec_t   recs[$];
  video_beat_t in_q[$];
  pixel_t      exp_q[$];
  logic [31:0] lcg_state;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          cycle_count = 0;
  int          cycle_limit = 0;

  tb_clock_gen u_clock_gen (.axis_aclk(axis_aclk), .axis_aresetn(axis_aresetn));

  dpc_top u_dpc_top (.*);

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic int group_of(input logic [7:0] kind);
    if (kind == "W" || kind == "R")
      return 1;
    if (kind == "P")
      return 2;
    return 3;
  endfunction

  task automatic load_stimulus();
    int          fd;
    int          beats;
    string       line;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    beats = 0;
    fd = $fopen("tests/dpc_top_stimulus.txt", "r");
    if (fd == 0)
    begin
      errors++;
      $display("could not open the stimulus file");
    end
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        a = '0;
        b = '0;
        c = '0;
        d = '0;
        void'($fgets(line, fd));
        if (line.len() < 2 || line[0] == "#")
          continue;
        if (line[0] == "G")
        begin
          void'($sscanf(line.substr(1, line.len() - 1), "%d %d %d", a, b, c));
          beats += a * b + c + 1;
        end
        else
        begin
          void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h %h", a, b, c, d));
          beats += 1;
        end
        if (line[0] != "W" && line[0] != "R" && line[0] != "P" && line[0] != "G")
        begin
          errors++;
          $display("unknown line kind in the stimulus file");
        end
        else
          recs.push_back({line[0], a, b, c, d});
      end
      $fclose(fd);
    end
    cycle_limit = 2 * beats + 200;
  endtask

  // one classic cycle, ack expected one cycle after the request
  task automatic bus_access(input logic we, input logic [31:0] adr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    int late;
    late = 0;
    @(negedge axis_aclk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr[WB_ADDR_WIDTH-1:0];
    wb_dat_w = wdata;
    @(negedge axis_aclk);
    while (!wb_ack && late < 4)
    begin
      late++;
      @(negedge axis_aclk);
    end
    rdata = wb_dat_r;
    checks++;
    if (!wb_ack)
    begin
      errors++;
      $display("no ack from the bus slave for address %h", adr[WB_ADDR_WIDTH-1:0]);
    end
    else if (late != 0)
    begin
      errors++;
      $display("Mismatch at %0t: ack %0d cycles late for address %h", $time, late,
               adr[WB_ADDR_WIDTH-1:0]);
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  // in_q and exp_q through the stream, outputs read at the falling edge
  task automatic play_frame(input logic random_ready);
    int          sent;
    int          got;
    int          cyc;
    int          first_in;
    int          first_out;
    logic [31:0] r;
    video_beat_t exp_beat;
    sent = 0;
    got = 0;
    cyc = 0;
    first_in = -1;
    first_out = -1;
    while (got < in_q.size())
    begin
      @(negedge axis_aclk);
      s_axis_tvalid = (sent < in_q.size());
      if (sent < in_q.size())
        {s_axis_tdata, s_axis_tuser, s_axis_tlast} = in_q[sent];
      r = lcg_next();
      m_axis_tready = random_ready ? (r[17:16] != 2'b00) : 1'b1;
      if (s_axis_tvalid && s_axis_tready)
      begin
        if (first_in < 0)
          first_in = cyc;
        sent++;
      end
      if (m_axis_tvalid && m_axis_tready)
      begin
        if (first_out < 0)
          first_out = cyc;
        exp_beat = {exp_q[got], in_q[got].sof, in_q[got].eol};
        checks++;
        if ({m_axis_tdata, m_axis_tuser, m_axis_tlast} !== exp_beat)
        begin
          errors++;
          $display("Mismatch at %0t: beat %0d got %h/%b/%b, expected %h/%b/%b", $time, got,
                   m_axis_tdata, m_axis_tuser, m_axis_tlast,
                   exp_beat.data, exp_beat.sof, exp_beat.eol);
        end
        got++;
      end
      cyc++;
    end
    @(negedge axis_aclk);
    s_axis_tvalid = 1'b0;
    m_axis_tready = 1'b1;
    checks++;
    if (m_axis_tvalid)
    begin
      errors++;
      $display("extra output beat after the end of the frame");
    end
    if (!random_ready)
    begin
      checks++;
      if (first_out - first_in != 3)
      begin
        errors++;
        $display("Mismatch at %0t: first output %0d cycles after first input, expected 3",
                 $time, first_out - first_in);
      end
    end
  endtask

  // random table and pixels, expected values from the correction rule
  task automatic random_frame(input logic [31:0] width, input logic [31:0] height,
                              input logic [31:0] entries);
    int          bad_x[BP_TABLE_DEPTH];
    int          bad_y[BP_TABLE_DEPTH];
    logic [31:0] r;
    logic [31:0] rdata;
    logic        bad;
    pixel_t      pix;
    for (int i = 0; i < entries; i++)
    begin
      r = lcg_next();
      bad_x[i] = int'(r % width);
      r = lcg_next();
      bad_y[i] = int'(r % height);
      bus_access(1'b1, 32'h10 + i, {6'b0, bad_y[i][9:0], 6'b0, bad_x[i][9:0]}, rdata);
    end
    bus_access(1'b1, 32'h0, {23'b0, 1'b1, 3'b0, entries[4:0]}, rdata);
    for (int y = 0; y < height; y++)
    begin
      for (int x = 0; x < width; x++)
      begin
        r = lcg_next();
        pix = r[PIXEL_WIDTH+7:8];
        bad = 1'b0;
        for (int i = 0; i < entries; i++)
          if (bad_x[i] == x && bad_y[i] == y)
            bad = 1'b1;
        in_q.push_back({pix, (x == 0 && y == 0), (x == width - 1)});
        exp_q.push_back((bad && x > 0) ? exp_q[$] : pix);
      end
    end
    play_frame(1'b1);
  endtask

  always @(posedge axis_aclk)
    cycle_count <= cycle_count + 1;

  initial
  begin
    wait (cycle_limit > 0);
    wait (cycle_count >= cycle_limit);
    $display("timeout: tests did not finish within %0d cycles", cycle_limit);
    $display("** FAIL **");
    $finish;
  end

  initial
  begin
    stim_rec_t   rec;
    int          idx;
    int          grp;
    int          start_errors;
    int          start_checks;
    logic [31:0] rdata;
    string       name;
    s_axis_tvalid = 1'b0;
    s_axis_tdata  = '0;
    s_axis_tuser  = 1'b0;
    s_axis_tlast  = 1'b0;
    m_axis_tready = 1'b1;
    wb_cyc        = 1'b0;
    wb_stb        = 1'b0;
    wb_we         = 1'b0;
    wb_adr        = '0;
    wb_dat_w      = '0;
    lcg_state     = 32'd86168;
    load_stimulus();
    wait (axis_aresetn === 1'b1);
    idx = 0;
    while (idx < recs.size())
    begin
      grp = group_of(recs[idx].kind);
      start_errors = errors;
      start_checks = checks;
      in_q.delete();
      exp_q.delete();
      do
      begin
        rec = recs[idx];
        idx++;
        case (rec.kind)
          "W": bus_access(1'b1, rec.a, rec.b, rdata);
          "R":
          begin
            bus_access(1'b0, rec.a, '0, rdata);
            checks++;
            if (rdata !== rec.b)
            begin
              errors++;
              $display("Mismatch at %0t: read of address %h gave %h, expected %h", $time,
                       rec.a[WB_ADDR_WIDTH-1:0], rdata, rec.b);
            end
          end
          "P":
          begin
            in_q.push_back({rec.a[PIXEL_WIDTH-1:0], rec.b[0], rec.c[0]});
            exp_q.push_back(rec.d[PIXEL_WIDTH-1:0]);
          end
          default: random_frame(rec.a, rec.b, rec.c);
        endcase
      end
      while (idx < recs.size() && grp != 3 && group_of(recs[idx].kind) == grp);
      if (grp == 2)
        play_frame(1'b0);
      name = (grp == 1) ? "bus access" : (grp == 2) ? "fixed frame" : "random frame";
      tests++;
      $display("test %0d %s done: %0d checks, %0d errors", tests, name,
               checks - start_checks, errors - start_errors);
    end
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

/* dpc_top.f */
source/dpc_pkg.sv
source/dpc_cfg_wb.sv
source/dpc_pixel_locator.sv
source/dpc_pixel_replacer.sv
source/dpc_output_skid.sv
source/dpc_top.sv
tests/tb_clock_gen.sv
tests/dpc_top_props.sv
tests/dpc_top_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the dpc_top testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f dpc_top.f --top-module dpc_top_tb
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/Vdpc_top_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '\*\* FAIL \*\*' "$LOG"; then
  exit 1
fi
exit 0

/* tests/dpc_top_stimulus.txt */
# W addr data | R addr expected | P pixel sof eol expected, all hex
# G width height entries, decimal
W 00 00000105
R 00 00000105
W 10 ffffffff
R 10 03ff03ff
W 1f 02aa0155
R 1f 02aa0155
W 10 00000001
W 00 00000001
R 00 00000001
# enable off, listed pixel (1,0) passes through
P 0100 1 0 0100
P 0200 0 0 0200
P 0300 0 0 0300
P 0400 0 1 0400
P 0500 0 0 0500
P 0600 0 0 0600
P 0700 0 0 0700
P 0800 0 1 0800
# index 3 lies beyond the count of 3
W 11 00000002
W 12 00010000
W 13 00010003
W 00 00000103
R 13 00010003
# adjacent bad pair, bad pixel in column 0, ignored entry at (3,1)
P 1000 1 0 1000
P 1100 0 0 1000
P 1200 0 0 1000
P 1300 0 1 1300
P 2000 0 0 2000
P 2100 0 0 2100
P 2200 0 0 2200
P 2300 0 1 2300
G 12 8 6
